// ==== verilog/dmem_pkg.sv ====
// Data path widths; MEM_WORDS must equal 2**IDX_W so addresses wrap modulo the array depth
package dmem_pkg;

  // ----------------------------------------------------------
  // Bus and memory geometry
  // ----------------------------------------------------------
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 64;

  // Bytes per data word
  localparam int STRB_W    = DATA_W / 8;

  // SRAM depth in words
  localparam int MEM_WORDS = 256;
  localparam int IDX_W     = 8;

  // Byte offset inside one word
  localparam int OFF_W     = 3;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------
  // Byte address as issued by the core
  typedef logic [ADDR_W-1:0] addr_t;

  // One bus data word
  typedef logic [DATA_W-1:0] data_t;

  // Write byte enables, bit n covers byte n
  typedef logic [STRB_W-1:0] strb_t;

  // SRAM word index
  typedef logic [IDX_W-1:0]  idx_t;

  // log2 of the access byte count, 0 byte up to 3 double
  typedef logic [1:0]        size_t;

endpackage

// ==== verilog/axil_pkg.sv ====
// AXI-lite response codes and FSM encodings; only the OKAY response is ever produced
package axil_pkg;

  // ----------------------------------------------------------
  // Response codes
  // ----------------------------------------------------------
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // ----------------------------------------------------------
  // State machines
  // ----------------------------------------------------------
  // Master, one transaction at a time
  typedef enum logic [2:0] {
    MST_IDLE,
    MST_WR_ADDR_DATA,
    MST_WR_RESP,
    MST_RD_ADDR,
    MST_RD_DATA
  } mst_state_t;

  // Slave write side
  typedef enum logic [1:0] {SWR_IDLE, SWR_ADDR, SWR_WRITE, SWR_RESP} slv_wr_state_t;

  // Slave read side
  typedef enum logic [1:0] {SRD_IDLE, SRD_ADDR, SRD_READ, SRD_DATA} slv_rd_state_t;

endpackage

// ==== verilog/lsu_align.sv ====
// Core-side request stage; addresses must be aligned to the access size, one access in flight
module lsu_align (
  input  logic              i_aclk,
  input  logic              i_arst_n,
  // Core side
  input  logic              i_req,
  input  logic              i_we,
  input  dmem_pkg::size_t   i_size,
  input  logic              i_unsigned,
  input  dmem_pkg::addr_t   i_addr,
  input  dmem_pkg::data_t   i_wdata,
  output logic              o_ready,
  output logic              o_done,
  output dmem_pkg::data_t   o_rdata,
  // Master side
  output logic              o_start,
  output logic              o_we,
  output dmem_pkg::addr_t   o_addr,
  output dmem_pkg::data_t   o_wdata,
  output dmem_pkg::strb_t   o_wstrb,
  input  logic              i_done,
  input  dmem_pkg::data_t   i_rdata
);

  logic                        busy;
  logic                        req_ok;
  logic [dmem_pkg::OFF_W-1:0]  off;
  logic [dmem_pkg::OFF_W-1:0]  off_q;
  dmem_pkg::size_t             size_q;
  logic                        unsigned_q;
  dmem_pkg::strb_t             size_mask;
  dmem_pkg::data_t             rd_shift;
  dmem_pkg::data_t             rd_ext;

  assign req_ok  = i_req & ~busy;
  assign off     = i_addr[dmem_pkg::OFF_W-1:0];
  assign o_ready = ~busy;

  // Byte lanes covered by the access before the offset shift
  always_comb begin
    case (i_size)
      2'd0:    size_mask = dmem_pkg::strb_t'(8'h01);
      2'd1:    size_mask = dmem_pkg::strb_t'(8'h03);
      2'd2:    size_mask = dmem_pkg::strb_t'(8'h0f);
      default: size_mask = '1;
    endcase
  end

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy    <= 1'b0;
      o_start <= 1'b0;
    end else begin
      o_start <= req_ok;
      if (req_ok) begin
        busy <= 1'b1;
      end else if (i_done) begin
        busy <= 1'b0;
      end
    end
  end

  // Payload held until the master reports done
  always_ff @(posedge i_aclk) begin
    if (req_ok) begin
      o_we       <= i_we;
      o_addr     <= {i_addr[dmem_pkg::ADDR_W-1:dmem_pkg::OFF_W], {dmem_pkg::OFF_W{1'b0}}};
      o_wstrb    <= size_mask << off;
      o_wdata    <= i_wdata << {off, 3'b000};
      size_q     <= i_size;
      unsigned_q <= i_unsigned;
      off_q      <= off;
    end
  end

  // ----------------------------------------------------------
  // Reply side, extraction and extension
  // ----------------------------------------------------------
  assign rd_shift = i_rdata >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      2'd0: rd_ext = unsigned_q ? {{(dmem_pkg::DATA_W-8){1'b0}}, rd_shift[7:0]}
                                : {{(dmem_pkg::DATA_W-8){rd_shift[7]}}, rd_shift[7:0]};
      2'd1: rd_ext = unsigned_q ? {{(dmem_pkg::DATA_W-16){1'b0}}, rd_shift[15:0]}
                                : {{(dmem_pkg::DATA_W-16){rd_shift[15]}}, rd_shift[15:0]};
      2'd2: rd_ext = unsigned_q ? {{(dmem_pkg::DATA_W-32){1'b0}}, rd_shift[31:0]}
                                : {{(dmem_pkg::DATA_W-32){rd_shift[31]}}, rd_shift[31:0]};
      default: rd_ext = rd_shift;
    endcase
  end

  // Stores return zero
  assign o_rdata = o_we ? '0 : rd_ext;
  assign o_done  = i_done;

endmodule

// ==== verilog/axil_lsu_master.sv ====
// AXI-lite master; one outstanding transaction, never issues a read and a write together
module axil_lsu_master (
  input  logic              i_aclk,
  input  logic              i_arst_n,
  // Request side
  input  logic              i_start,
  input  logic              i_we,
  input  dmem_pkg::addr_t   i_addr,
  input  dmem_pkg::data_t   i_wdata,
  input  dmem_pkg::strb_t   i_wstrb,
  output logic              o_done,
  output dmem_pkg::data_t   o_rdata,
  // Write address channel
  output logic              o_awvalid,
  input  logic              i_awready,
  output dmem_pkg::addr_t   o_awaddr,
  // Write data channel
  output logic              o_wvalid,
  input  logic              i_wready,
  output dmem_pkg::data_t   o_wdata,
  output dmem_pkg::strb_t   o_wstrb,
  // Write response channel
  input  logic              i_bvalid,
  output logic              o_bready,
  input  axil_pkg::resp_t   i_bresp,
  // Read address channel
  output logic              o_arvalid,
  input  logic              i_arready,
  output dmem_pkg::addr_t   o_araddr,
  // Read data channel
  input  logic              i_rvalid,
  output logic              o_rready,
  input  dmem_pkg::data_t   i_rdata,
  input  axil_pkg::resp_t   i_rresp
);

  axil_pkg::mst_state_t state;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 b_fire;
  logic                 ar_fire;
  logic                 r_fire;
  logic                 aw_done;
  logic                 w_done;
  axil_pkg::resp_t      cur_resp;
  dmem_pkg::data_t      ret_word;
  dmem_pkg::data_t      rdata_q;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid & i_wready;
  assign b_fire  = i_bvalid & o_bready;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = i_rvalid & o_rready;

  // AW and W may complete in either order
  assign aw_done = ~o_awvalid | aw_fire;
  assign w_done  = ~o_wvalid | w_fire;

  assign o_bready = (state == axil_pkg::MST_WR_RESP);
  assign o_rready = (state == axil_pkg::MST_RD_DATA);

  // ----------------------------------------------------------
  // Transaction FSM
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= axil_pkg::MST_IDLE;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
      o_arvalid <= 1'b0;
    end else begin
      case (state)
        axil_pkg::MST_IDLE: begin
          if (i_start && i_we) begin
            state     <= axil_pkg::MST_WR_ADDR_DATA;
            o_awvalid <= 1'b1;
            o_wvalid  <= 1'b1;
          end else if (i_start) begin
            state     <= axil_pkg::MST_RD_ADDR;
            o_arvalid <= 1'b1;
          end
        end
        axil_pkg::MST_WR_ADDR_DATA: begin
          if (aw_fire) o_awvalid <= 1'b0;
          if (w_fire) o_wvalid <= 1'b0;
          if (aw_done && w_done) state <= axil_pkg::MST_WR_RESP;
        end
        axil_pkg::MST_WR_RESP: if (b_fire) state <= axil_pkg::MST_IDLE;
        axil_pkg::MST_RD_ADDR: begin
          if (ar_fire) begin
            o_arvalid <= 1'b0;
            state     <= axil_pkg::MST_RD_DATA;
          end
        end
        axil_pkg::MST_RD_DATA: if (r_fire) state <= axil_pkg::MST_IDLE;
        default: state <= axil_pkg::MST_IDLE;
      endcase
    end
  end

  // Channel payload, stable while the valids are up
  always_ff @(posedge i_aclk) begin
    if (i_start && state == axil_pkg::MST_IDLE) begin
      o_awaddr <= i_addr;
      o_araddr <= i_addr;
      o_wdata  <= i_wdata;
      o_wstrb  <= i_wstrb;
    end
  end

  // ----------------------------------------------------------
  // Reply
  // ----------------------------------------------------------
  assign cur_resp = o_bready ? i_bresp : i_rresp;

  // Failed responses return zero data
  assign ret_word = (cur_resp == axil_pkg::RESP_OKAY) ? i_rdata : '0;

  always_ff @(posedge i_aclk) begin
    if (r_fire) rdata_q <= ret_word;
  end

  // Read word is passed through on the R transfer itself
  assign o_rdata = r_fire ? ret_word : rdata_q;
  assign o_done  = b_fire | r_fire;

endmodule

// ==== verilog/axil_data_sram_wrap.sv ====
// AXI-lite slave for the data SRAM; always answers OKAY, reads and writes must not overlap
module axil_data_sram_wrap (
  input  logic              i_aclk,
  input  logic              i_arst_n,
  // Write address channel
  input  logic              i_awvalid,
  output logic              o_awready,
  input  dmem_pkg::addr_t   i_awaddr,
  // Write data channel
  input  logic              i_wvalid,
  output logic              o_wready,
  input  dmem_pkg::data_t   i_wdata,
  input  dmem_pkg::strb_t   i_wstrb,
  // Write response channel
  output logic              o_bvalid,
  input  logic              i_bready,
  output axil_pkg::resp_t   o_bresp,
  // Read address channel
  input  logic              i_arvalid,
  output logic              o_arready,
  input  dmem_pkg::addr_t   i_araddr,
  // Read data channel
  output logic              o_rvalid,
  input  logic              i_rready,
  output dmem_pkg::data_t   o_rdata,
  output axil_pkg::resp_t   o_rresp,
  // SRAM ports
  output logic              o_mem_we,
  output dmem_pkg::idx_t    o_mem_widx,
  output dmem_pkg::data_t   o_mem_wdata,
  output dmem_pkg::strb_t   o_mem_wstrb,
  output logic              o_mem_re,
  output dmem_pkg::idx_t    o_mem_ridx,
  input  dmem_pkg::data_t   i_mem_rdata
);

  axil_pkg::slv_wr_state_t wr_state;
  axil_pkg::slv_rd_state_t rd_state;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;
  logic                    ar_fire;
  logic                    r_fire;
  dmem_pkg::idx_t          widx_q;
  dmem_pkg::data_t         rdata_q;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // Handshake outputs decoded from state
  assign o_awready = (wr_state == axil_pkg::SWR_ADDR);
  assign o_wready  = (wr_state == axil_pkg::SWR_WRITE);
  assign o_bvalid  = (wr_state == axil_pkg::SWR_RESP);
  assign o_arready = (rd_state == axil_pkg::SRD_ADDR);
  assign o_rvalid  = (rd_state == axil_pkg::SRD_DATA);
  assign o_bresp   = axil_pkg::RESP_OKAY;
  assign o_rresp   = axil_pkg::RESP_OKAY;

  // ----------------------------------------------------------
  // Write side
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state <= axil_pkg::SWR_IDLE;
    end else begin
      case (wr_state)
        axil_pkg::SWR_IDLE:  if (i_awvalid) wr_state <= axil_pkg::SWR_ADDR;
        axil_pkg::SWR_ADDR:  if (aw_fire) wr_state <= axil_pkg::SWR_WRITE;
        axil_pkg::SWR_WRITE: if (w_fire) wr_state <= axil_pkg::SWR_RESP;
        axil_pkg::SWR_RESP:  if (b_fire) wr_state <= axil_pkg::SWR_IDLE;
        default:             wr_state <= axil_pkg::SWR_IDLE;
      endcase
    end
  end

  // Word index, offset bits dropped and upper bits wrap
  always_ff @(posedge i_aclk) begin
    if (aw_fire) widx_q <= i_awaddr[dmem_pkg::OFF_W +: dmem_pkg::IDX_W];
  end

  assign o_mem_we    = w_fire;
  assign o_mem_widx  = widx_q;
  assign o_mem_wdata = i_wdata;
  assign o_mem_wstrb = i_wstrb;

  // ----------------------------------------------------------
  // Read side
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state <= axil_pkg::SRD_IDLE;
    end else begin
      case (rd_state)
        axil_pkg::SRD_IDLE: if (i_arvalid) rd_state <= axil_pkg::SRD_ADDR;
        axil_pkg::SRD_ADDR: if (ar_fire) rd_state <= axil_pkg::SRD_READ;
        axil_pkg::SRD_READ: rd_state <= axil_pkg::SRD_DATA;
        axil_pkg::SRD_DATA: if (r_fire) rd_state <= axil_pkg::SRD_IDLE;
        default:            rd_state <= axil_pkg::SRD_IDLE;
      endcase
    end
  end

  // SRAM read issued on the AR transfer, araddr is stable in that cycle
  assign o_mem_re   = ar_fire;
  assign o_mem_ridx = i_araddr[dmem_pkg::OFF_W +: dmem_pkg::IDX_W];

  // Held until the R transfer
  always_ff @(posedge i_aclk) begin
    if (rd_state == axil_pkg::SRD_READ) rdata_q <= i_mem_rdata;
  end

  assign o_rdata = rdata_q;

endmodule

// ==== verilog/data_sram.sv ====
// Byte-writable data SRAM without reset; a word must be written before it is read
module data_sram (
  input  logic              i_aclk,
  // Write port
  input  logic              i_we,
  input  dmem_pkg::idx_t    i_widx,
  input  dmem_pkg::data_t   i_wdata,
  input  dmem_pkg::strb_t   i_wstrb,
  // Read port, data one cycle after i_re
  input  logic              i_re,
  input  dmem_pkg::idx_t    i_ridx,
  output dmem_pkg::data_t   o_rdata
);

  dmem_pkg::data_t mem [dmem_pkg::MEM_WORDS];

  // ----------------------------------------------------------
  // Write, one byte lane per strobe bit
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < dmem_pkg::STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[i_widx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Registered read
  // ----------------------------------------------------------
  // Output holds its last value while i_re is low
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_ridx];
    end
  end

endmodule

// ==== verilog/dmem_top.sv ====
// Data-memory subsystem top; aligned accesses only, one request at a time via o_ready
module dmem_top (
  input  logic              i_aclk,
  input  logic              i_arst_n,
  input  logic              i_req,
  input  logic              i_we,
  input  dmem_pkg::size_t   i_size,
  input  logic              i_unsigned,
  input  dmem_pkg::addr_t   i_addr,
  input  dmem_pkg::data_t   i_wdata,
  output logic              o_ready,
  output logic              o_done,
  output dmem_pkg::data_t   o_rdata
);

  // ----------------------------------------------------------
  // Stage interconnect
  // ----------------------------------------------------------
  // Align to master
  logic            start;
  logic            req_we;
  dmem_pkg::addr_t req_addr;
  dmem_pkg::data_t req_wdata;
  dmem_pkg::strb_t req_wstrb;
  logic            mst_done;
  dmem_pkg::data_t mst_rdata;

  // AXI-lite channels
  logic            awvalid, awready;
  dmem_pkg::addr_t awaddr;
  logic            wvalid, wready;
  dmem_pkg::data_t wdata;
  dmem_pkg::strb_t wstrb;
  logic            bvalid, bready;
  axil_pkg::resp_t bresp;
  logic            arvalid, arready;
  dmem_pkg::addr_t araddr;
  logic            rvalid, rready;
  dmem_pkg::data_t rdata;
  axil_pkg::resp_t rresp;

  // SRAM ports
  logic            mem_we, mem_re;
  dmem_pkg::idx_t  mem_widx, mem_ridx;
  dmem_pkg::data_t mem_wdata, mem_rdata;
  dmem_pkg::strb_t mem_wstrb;

  lsu_align u_align (
    .i_aclk(i_aclk), .i_arst_n(i_arst_n),
    .i_req(i_req), .i_we(i_we), .i_size(i_size), .i_unsigned(i_unsigned),
    .i_addr(i_addr), .i_wdata(i_wdata),
    .o_ready(o_ready), .o_done(o_done), .o_rdata(o_rdata),
    .o_start(start), .o_we(req_we), .o_addr(req_addr), .o_wdata(req_wdata),
    .o_wstrb(req_wstrb), .i_done(mst_done), .i_rdata(mst_rdata)
  );

  axil_lsu_master u_master (
    .i_aclk(i_aclk), .i_arst_n(i_arst_n),
    .i_start(start), .i_we(req_we), .i_addr(req_addr), .i_wdata(req_wdata),
    .i_wstrb(req_wstrb), .o_done(mst_done), .o_rdata(mst_rdata),
    .o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr),
    .o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
    .i_bvalid(bvalid), .o_bready(bready), .i_bresp(bresp),
    .o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr),
    .i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata), .i_rresp(rresp)
  );

  axil_data_sram_wrap u_slave (
    .i_aclk(i_aclk), .i_arst_n(i_arst_n),
    .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
    .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
    .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
    .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
    .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
    .o_mem_we(mem_we), .o_mem_widx(mem_widx), .o_mem_wdata(mem_wdata),
    .o_mem_wstrb(mem_wstrb), .o_mem_re(mem_re), .o_mem_ridx(mem_ridx),
    .i_mem_rdata(mem_rdata)
  );

  data_sram u_sram (
    .i_aclk(i_aclk),
    .i_we(mem_we), .i_widx(mem_widx), .i_wdata(mem_wdata), .i_wstrb(mem_wstrb),
    .i_re(mem_re), .i_ridx(mem_ridx), .o_rdata(mem_rdata)
  );

endmodule

// ==== dv/dmem_tb.sv ====
// Random accesses stay in 16 prefilled words and their upper address bits wrap into them
module dmem_tb;

  // Byte-addressed mirror of the whole SRAM
  localparam int BIDX_W       = dmem_pkg::IDX_W + dmem_pkg::OFF_W;
  localparam int MIRROR_BYTES = dmem_pkg::MEM_WORDS * dmem_pkg::STRB_W;
  localparam int RAND_OPS     = 250;
  // About 316 accesses of under 12 cycles each with their idle gaps plus margin
  localparam int MAX_CYCLES   = 4000;

  logic            i_aclk;
  logic            i_arst_n;
  logic            i_req;
  logic            i_we;
  dmem_pkg::size_t i_size;
  logic            i_unsigned;
  dmem_pkg::addr_t i_addr;
  dmem_pkg::data_t i_wdata;
  logic            o_ready;
  logic            o_done;
  dmem_pkg::data_t o_rdata;

  logic [7:0]      mirror [MIRROR_BYTES];
  dmem_pkg::data_t exp_q [$];
  dmem_pkg::data_t exp_word;
  dmem_pkg::addr_t rnd_addr;
  dmem_pkg::size_t rnd_size;
  logic [31:0]     r;
  integer          seed;
  int              cycle_cnt;

  dmem_top u_dut (
    .i_aclk(i_aclk), .i_arst_n(i_arst_n),
    .i_req(i_req), .i_we(i_we), .i_size(i_size), .i_unsigned(i_unsigned),
    .i_addr(i_addr), .i_wdata(i_wdata),
    .o_ready(o_ready), .o_done(o_done), .o_rdata(o_rdata)
  );

  always #50 i_aclk = ~i_aclk;

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // Low bytes of the store data land at addr and upward
  task automatic write_mirror(input dmem_pkg::addr_t addr, input dmem_pkg::size_t size,
                              input dmem_pkg::data_t wdata);
    logic [BIDX_W-1:0] bi;
    for (int b = 0; b < (1 << size); b++) begin
      bi = addr[BIDX_W-1:0] + BIDX_W'(b);
      mirror[bi] = wdata[b*8 +: 8];
    end
  endtask

  // Little-endian gather then sign or zero fill above the access size
  function automatic dmem_pkg::data_t expect_load(input dmem_pkg::addr_t addr,
                                                  input dmem_pkg::size_t size,
                                                  input logic uns);
    dmem_pkg::data_t   val;
    logic [BIDX_W-1:0] bi;
    int                nbytes;
    val    = '0;
    nbytes = 1 << size;
    for (int b = 0; b < nbytes; b++) begin
      bi = addr[BIDX_W-1:0] + BIDX_W'(b);
      val[b*8 +: 8] = mirror[bi];
    end
    if (!uns && val[nbytes*8-1]) begin
      for (int b = nbytes; b < dmem_pkg::STRB_W; b++) begin
        val[b*8 +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  // ----------------------------------------------------------
  // Stimulus helpers for the falling edge
  // ----------------------------------------------------------
  task automatic issue_access(input logic we, input dmem_pkg::size_t size, input logic uns,
                              input dmem_pkg::addr_t addr, input dmem_pkg::data_t wdata);
    while (o_ready !== 1'b1) begin
      @(negedge i_aclk);
    end
    i_req      = 1'b1;
    i_we       = we;
    i_size     = size;
    i_unsigned = uns;
    i_addr     = addr;
    i_wdata    = wdata;
    if (we) begin
      write_mirror(addr, size, wdata);
      exp_q.push_back(dmem_pkg::data_t'(0));
    end else begin
      exp_q.push_back(expect_load(addr, size, uns));
    end
    @(negedge i_aclk);
    i_req = 1'b0;
  endtask

  // Idle cycles with o_ready high before the next request
  task automatic idle_gap();
    r = $random(seed);
    while (o_ready !== 1'b1) begin
      @(negedge i_aclk);
    end
    repeat (r[1:0]) @(negedge i_aclk);
  endtask

  // ----------------------------------------------------------
  // Response checker
  // ----------------------------------------------------------
  always @(negedge i_aclk) begin
    if (i_arst_n === 1'b1 && o_done === 1'b1) begin
      assert (exp_q.size() > 0)
        else abort_run("o_done pulsed with no request outstanding");
      exp_word = exp_q.pop_front();
      assert (o_rdata === exp_word)
        else abort_run($sformatf("** Error at %0t: o_rdata = %h, expected %h",
                                 $time, o_rdata, exp_word));
    end
  end

  always @(posedge i_aclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run("Timeout: the accesses did not finish in time");
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    i_aclk     = 1'b0;
    i_arst_n   = 1'b0;
    i_req      = 1'b0;
    i_we       = 1'b0;
    i_size     = '0;
    i_unsigned = 1'b0;
    i_addr     = '0;
    i_wdata    = '0;
    seed       = 32'hd7d0;
    cycle_cnt  = 0;
    repeat (3) @(posedge i_aclk);
    @(negedge i_aclk);
    i_arst_n = 1'b1;
    @(negedge i_aclk);
    assert (o_ready === 1'b1 && o_done === 1'b0)
      else abort_run("o_ready not high or o_done not low after reset");

    // Fill the 16-word test window before any load
    for (int w = 0; w < 16; w++) begin
      issue_access(1'b1, 2'd3, 1'b0, dmem_pkg::addr_t'(w * 8), {$random(seed), $random(seed)});
    end

    // Doubleword round trip
    issue_access(1'b1, 2'd3, 1'b0, 32'h38, 64'h0123_4567_89ab_cdef);
    issue_access(1'b0, 2'd3, 1'b0, 32'h38, '0);

    // Each partial store is read back as a whole doubleword
    for (int o = 0; o < 8; o++) begin
      issue_access(1'b1, 2'd0, 1'b0, dmem_pkg::addr_t'(32'h40 + o),
                   {$random(seed), $random(seed)});
      issue_access(1'b0, 2'd3, 1'b0, 32'h40, '0);
    end
    for (int o = 0; o < 8; o += 2) begin
      issue_access(1'b1, 2'd1, 1'b0, dmem_pkg::addr_t'(32'h48 + o),
                   {$random(seed), $random(seed)});
      issue_access(1'b0, 2'd3, 1'b0, 32'h48, '0);
    end
    for (int o = 0; o < 8; o += 4) begin
      issue_access(1'b1, 2'd2, 1'b0, dmem_pkg::addr_t'(32'h50 + o),
                   {$random(seed), $random(seed)});
      issue_access(1'b0, 2'd3, 1'b0, 32'h50, '0);
    end

    // Top bit set at every size and then clear
    issue_access(1'b1, 2'd3, 1'b0, 32'h60, 64'h8899_aabb_ccdd_eeff);
    issue_access(1'b1, 2'd3, 1'b0, 32'h68, 64'h7766_5544_3322_1111);
    for (int s = 0; s < 4; s++) begin
      issue_access(1'b0, dmem_pkg::size_t'(s), 1'b0, 32'h60, '0);
      issue_access(1'b0, dmem_pkg::size_t'(s), 1'b1, 32'h60, '0);
      issue_access(1'b0, dmem_pkg::size_t'(s), 1'b0, 32'h68, '0);
      issue_access(1'b0, dmem_pkg::size_t'(s), 1'b1, 32'h68, '0);
    end

    // Random mix with upper address bits aliasing back into the window
    for (int i = 0; i < RAND_OPS; i++) begin
      r        = $random(seed);
      rnd_size = r[1:0];
      rnd_addr = $random(seed) & 32'hffff_f87f;
      rnd_addr = rnd_addr & ~((32'd1 << rnd_size) - 32'd1);
      issue_access(r[2], rnd_size, r[3], rnd_addr, {$random(seed), $random(seed)});
      idle_gap();
    end

    // Strobe while busy must be dropped
    issue_access(1'b1, 2'd3, 1'b0, 32'h70, 64'h0f1e_2d3c_4b5a_6978);
    assert (o_ready === 1'b0)
      else abort_run("o_ready stayed high while a store was in flight");
    i_req   = 1'b1;
    i_we    = 1'b1;
    i_size  = 2'd3;
    i_addr  = 32'h70;
    i_wdata = 64'hffff_0000_ffff_0000;
    @(negedge i_aclk);
    i_req = 1'b0;
    issue_access(1'b0, 2'd3, 1'b0, 32'h70, '0);

    while (exp_q.size() != 0) begin
      @(negedge i_aclk);
    end
    repeat (4) @(negedge i_aclk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/dmem_pkg.sv
verilog/axil_pkg.sv
verilog/lsu_align.sv
verilog/axil_lsu_master.sv
verilog/axil_data_sram_wrap.sv
verilog/data_sram.sv
verilog/dmem_top.sv
dv/dmem_tb.sv

// ==== Makefile ====
TOP = dmem_tb

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
